// ==== wbb_subsys_top.f ====
+incdir+.
wbb_bus_pkg.sv
wbb_map_pkg.sv
wbc2pipeline.sv
wbp_decoder.sv
wbp_ram_slave.sv
wbp_resp_mux.sv
wbb_subsys_top.sv
tb_wbb_subsys.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bridge subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
TOP=tb_wbb_subsys
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps --top-module "$TOP" \
	-f wbb_subsys_top.f -Mdir obj_dir \
	&& ./obj_dir/V"$TOP" > "$LOG" 2>&1 \
	|| { cat "$LOG" 2>/dev/null; echo "Build or simulation did not complete"; exit 1; }

cat "$LOG"
grep -q "TESTS FAILED" "$LOG" && { echo "Simulation reported a failure"; exit 1; }
grep -q "TESTS PASSED" "$LOG" || { echo "No pass line found in the log"; exit 1; }
exit 0

// ==== tb_wbb_subsys.sv ====
//////////////////////////////////////////////////////////////////////
// Directed testbench for the Wishbone bridge subsystem
// Classic master tasks, byte-lane reference model, timeout, summary
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module tb_wbb_subsys;
	timeunit 1ns;
	timeprecision 100ps;

	// Requests issued by all tests together, 6 cycles each at most
	localparam int N_REQ   = 84;
	localparam int TIMEOUT = N_REQ * 6 + 100;
	localparam int N_WORDS = `WBB_N_SLAVES * `WBB_SLV_WORDS;

	logic               i_clk;
	logic               i_rst_n;
	logic               i_mcyc;
	logic               i_mstb;
	logic               i_mwe;
	wbb_bus_pkg::addr_t i_maddr;
	wbb_bus_pkg::data_t i_mdata;
	wbb_bus_pkg::sel_t  i_msel;
	logic               o_mack;
	logic               o_merr;
	wbb_bus_pkg::data_t o_mdata;

	// Reference memory and the byte lanes written so far
	wbb_bus_pkg::data_t model_mem [N_WORDS];
	wbb_bus_pkg::sel_t  model_vld [N_WORDS];

	integer seed   = 32'h8bda_9b0b;
	int     errors = 0;
	int     n_req  = 0;
	int     cycles = 0;

	wbb_subsys_top i_dut (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_mcyc(i_mcyc), .i_mstb(i_mstb), .i_mwe(i_mwe),
		.i_maddr(i_maddr), .i_mdata(i_mdata), .i_msel(i_msel),
		.o_mack(o_mack), .o_merr(o_merr), .o_mdata(o_mdata)
	);

	// 40 ns clock
	initial
	begin
		i_clk = 1'b0;
		forever #20 i_clk = ~i_clk;
	end

	always @(posedge i_clk)
		cycles <= cycles + 1;

	// Watchdog
	initial
	begin
		wait (cycles >= TIMEOUT);
		$display("Timeout: run hung, still busy after %0d cycles", cycles);
		$display("TESTS FAILED");
		$finish;
	end

	task automatic report_error(input string msg);
		errors++;
		$display("ERROR @ %0d ns: %s", $time, msg);
	endtask

	// Window base plus word offset
	function automatic wbb_bus_pkg::addr_t window_addr(input int idx, input int off);
		return wbb_bus_pkg::addr_t'(idx * `WBB_SLV_WORDS + off);
	endfunction

	// Index past the last slave has no target
	function automatic bit is_unmapped(input wbb_bus_pkg::addr_t addr);
		int idx;
		idx = int'(addr[`WBB_AW-1:`WBB_SLV_AW]);
		return idx >= `WBB_N_SLAVES;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Classic master

	// Request held until ack or error, released on the next edge
	task automatic classic_cycle(input logic we, input wbb_bus_pkg::addr_t addr,
		input wbb_bus_pkg::data_t wdata, input wbb_bus_pkg::sel_t sel,
		output wbb_bus_pkg::data_t rdata, output logic ack, output logic err);
		int lat;
		@(posedge i_clk);
		i_mcyc  <= 1'b1;
		i_mstb  <= 1'b1;
		i_mwe   <= we;
		i_maddr <= addr;
		i_mdata <= wdata;
		i_msel  <= sel;
		n_req++;
		lat = 0;
		ack = 1'b0;
		err = 1'b0;
		while (!ack && !err)
		begin
			@(posedge i_clk);
			lat++;
			@(negedge i_clk);
			ack = o_mack;
			err = o_merr;
		end
		rdata = o_mdata;
		if (ack && err)
			report_error($sformatf("ack and error together at 0x%03h", addr));
		if (lat != 2)
			report_error($sformatf("response at 0x%03h after %0d cycles, expected 2",
				addr, lat));
		if (err != is_unmapped(addr))
			report_error($sformatf("error flag %0b at 0x%03h is wrong", err, addr));
		@(posedge i_clk);
		i_mcyc <= 1'b0;
		i_mstb <= 1'b0;
		i_mwe  <= 1'b0;
		// Response pulse must be gone one cycle later
		@(negedge i_clk);
		if (o_mack || o_merr)
			report_error($sformatf("response at 0x%03h lasted over one cycle", addr));
	endtask

	task automatic wb_write(input wbb_bus_pkg::addr_t addr, input wbb_bus_pkg::data_t data,
		input wbb_bus_pkg::sel_t sel);
		wbb_bus_pkg::data_t rdata;
		logic ack;
		logic err;
		classic_cycle(1'b1, addr, data, sel, rdata, ack, err);
		if (!is_unmapped(addr))
		begin
			for (int b = 0; b < `WBB_SEL_W; b++)
			begin
				if (sel[b])
				begin
					model_mem[addr][8*b +: 8] = data[8*b +: 8];
					model_vld[addr][b] = 1'b1;
				end
			end
		end
	endtask

	// Only bytes written earlier are compared
	task automatic wb_read(input wbb_bus_pkg::addr_t addr);
		wbb_bus_pkg::data_t rdata;
		wbb_bus_pkg::data_t mask;
		logic ack;
		logic err;
		classic_cycle(1'b0, addr, '0, '0, rdata, ack, err);
		if (ack && !is_unmapped(addr))
		begin
			for (int b = 0; b < `WBB_SEL_W; b++)
				mask[8*b +: 8] = {8{model_vld[addr][b]}};
			if (((rdata ^ model_mem[addr]) & mask) != '0)
				report_error($sformatf("read 0x%03h gave 0x%08h, expected 0x%08h",
					addr, rdata, model_mem[addr]));
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Directed tests

	task automatic reset_state_test();
		repeat (4)
		begin
			@(negedge i_clk);
			if (o_mack || o_merr)
				report_error("response seen while idle after reset");
		end
	endtask

	task automatic full_word_test();
		for (int k = 0; k < `WBB_N_SLAVES; k++)
		begin
			wb_write(window_addr(k, 16 + k), $random(seed), '1);
			wb_read(window_addr(k, 16 + k));
		end
	endtask

	// Different lane pattern per slave
	task automatic byte_lane_test();
		for (int k = 0; k < `WBB_N_SLAVES; k++)
		begin
			wb_write(window_addr(k, 32), $random(seed), '1);
			wb_write(window_addr(k, 32), $random(seed), wbb_bus_pkg::sel_t'(4'b0101 << k));
			wb_read(window_addr(k, 32));
		end
	endtask

	task automatic unmapped_test();
		wb_write(window_addr(3, 32), $random(seed), '1);
		wb_read(window_addr(3, 32));
		// Slave 0 at the same offset must be untouched
		wb_read(window_addr(0, 32));
	endtask

	task automatic isolation_test();
		for (int k = 0; k < `WBB_N_SLAVES; k++)
			wb_write(window_addr(k, 64), 32'hc0de_0000 + k, '1);
		for (int k = 0; k < `WBB_N_SLAVES; k++)
			wb_read(window_addr(k, 64));
	endtask

	// Small offset range so reads hit earlier writes
	task automatic random_test();
		logic [31:0] r;
		for (int n = 0; n < 60; n++)
		begin
			r = $random(seed);
			if (r[6])
				wb_write({r[1:0], 4'h0, r[5:2]}, $random(seed), r[11:8]);
			else
				wb_read({r[1:0], 4'h0, r[5:2]});
		end
	endtask

	initial
	begin
		i_rst_n = 1'b0;
		i_mcyc  = 1'b0;
		i_mstb  = 1'b0;
		i_mwe   = 1'b0;
		i_maddr = '0;
		i_mdata = '0;
		i_msel  = '0;
		for (int a = 0; a < N_WORDS; a++)
		begin
			model_mem[a] = '0;
			model_vld[a] = '0;
		end
		repeat (2) @(posedge i_clk);
		i_rst_n <= 1'b1;
		reset_state_test();
		full_word_test();
		byte_lane_test();
		unmapped_test();
		isolation_test();
		random_test();
		@(posedge i_clk);
		$display("Summary: %0d requests, %0d errors", n_req, errors);
		if (errors == 0)
			$display("TESTS PASSED");
		else
			$display("TESTS FAILED");
		$finish;
	end

endmodule

// ==== wbb_subsys_top.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone bridge subsystem top level
// Bridge, address decoder, RAM slaves and response mux
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module wbb_subsys_top (
	input  logic               i_clk,
	input  logic               i_rst_n,
	input  logic               i_mcyc,
	input  logic               i_mstb,
	input  logic               i_mwe,
	input  wbb_bus_pkg::addr_t i_maddr,
	input  wbb_bus_pkg::data_t i_mdata,
	input  wbb_bus_pkg::sel_t  i_msel,
	output logic               o_mack,
	output logic               o_merr,
	output wbb_bus_pkg::data_t o_mdata
);

	// Bridge to decoder pipelined bus
	logic p_cyc, p_stb, p_we, p_stall, p_ack, p_err;
	wbb_bus_pkg::addr_t p_addr;
	wbb_bus_pkg::data_t p_data, p_rdata;
	wbb_bus_pkg::sel_t  p_sel;

	// Decoder to slave lines
	logic s_cyc, s_we;
	logic [`WBB_N_SLAVES-1:0] s_stb, s_stall, s_ack, s_err;
	wbb_bus_pkg::slv_addr_t s_addr;
	wbb_bus_pkg::data_t     s_data;
	wbb_bus_pkg::sel_t      s_sel;
	wbb_bus_pkg::data_t     s_rdata [`WBB_N_SLAVES];

	// Decoder to mux
	wbb_map_pkg::slv_idx_t d_idx;
	logic d_err, d_resp;

	wbc2pipeline u_bridge (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_mcyc(i_mcyc), .i_mstb(i_mstb), .i_mwe(i_mwe),
		.i_maddr(i_maddr), .i_mdata(i_mdata), .i_msel(i_msel),
		.o_mack(o_mack), .o_merr(o_merr), .o_mdata(o_mdata),
		.o_scyc(p_cyc), .o_sstb(p_stb), .o_swe(p_we),
		.o_saddr(p_addr), .o_sdata(p_data), .o_ssel(p_sel),
		.i_sstall(p_stall), .i_sack(p_ack), .i_serr(p_err), .i_sdata(p_rdata)
	);

	wbp_decoder u_decoder (
		.i_clk(i_clk), .i_rst_n(i_rst_n),
		.i_cyc(p_cyc), .i_stb(p_stb), .i_we(p_we),
		.i_addr(p_addr), .i_data(p_data), .i_sel(p_sel), .o_stall(p_stall),
		.o_scyc(s_cyc), .o_sstb(s_stb), .o_swe(s_we),
		.o_saddr(s_addr), .o_sdata(s_data), .o_ssel(s_sel),
		.i_sstall(s_stall), .i_resp(d_resp), .o_idx(d_idx), .o_err(d_err)
	);

	// One RAM per mapped window
	for (genvar k = 0; k < `WBB_N_SLAVES; k++)
	begin : gen_slv
		wbp_ram_slave u_ram (
			.i_clk(i_clk), .i_rst_n(i_rst_n),
			.i_cyc(s_cyc), .i_stb(s_stb[k]), .i_we(s_we),
			.i_addr(s_addr), .i_data(s_data), .i_sel(s_sel),
			.o_stall(s_stall[k]), .o_ack(s_ack[k]), .o_err(s_err[k]),
			.o_rdata(s_rdata[k])
		);
	end

	wbp_resp_mux u_resp_mux (
		.i_idx(d_idx), .i_dec_err(d_err),
		.i_ack(s_ack), .i_err(s_err), .i_rdata(s_rdata),
		.o_ack(p_ack), .o_err(p_err), .o_rdata(p_rdata), .o_resp(d_resp)
	);

endmodule

// ==== wbp_resp_mux.sv ====
//////////////////////////////////////////////////////////////////////
// Pipelined response multiplexer
// Selects the recorded slave response and merges the decoder error
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module wbp_resp_mux (
	input  wbb_map_pkg::slv_idx_t   i_idx,
	input  logic                    i_dec_err,
	input  logic [`WBB_N_SLAVES-1:0] i_ack,
	input  logic [`WBB_N_SLAVES-1:0] i_err,
	input  wbb_bus_pkg::data_t      i_rdata [`WBB_N_SLAVES],
	output logic                    o_ack,
	output logic                    o_err,
	output wbb_bus_pkg::data_t      o_rdata,
	output logic                    o_resp
);

	logic slv_err;

	// Only the recorded target is listened to
	always_comb
	begin
		o_ack   = 1'b0;
		slv_err = 1'b0;
		o_rdata = '0;
		for (int k = 0; k < `WBB_N_SLAVES; k++)
		begin
			if (i_idx == wbb_map_pkg::slv_idx_t'(k))
			begin
				o_ack   = i_ack[k];
				slv_err = i_err[k];
				o_rdata = i_rdata[k];
			end
		end
	end

	// Unmapped accesses are answered by the decoder
	assign o_err = slv_err || i_dec_err;

	// Releases the decoder back to idle
	assign o_resp = o_ack || o_err;

endmodule

// ==== wbp_ram_slave.sv ====
//////////////////////////////////////////////////////////////////////
// Pipelined Wishbone RAM slave
// Byte-lane writes, registered reads, stall while ack pending
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module wbp_ram_slave (
	input  logic                   i_clk,
	input  logic                   i_rst_n,
	input  logic                   i_cyc,
	input  logic                   i_stb,
	input  logic                   i_we,
	input  wbb_bus_pkg::slv_addr_t i_addr,
	input  wbb_bus_pkg::data_t     i_data,
	input  wbb_bus_pkg::sel_t      i_sel,
	output logic                   o_stall,
	output logic                   o_ack,
	output logic                   o_err,
	output wbb_bus_pkg::data_t     o_rdata
);

	// Storage for one slave window
	wbb_bus_pkg::data_t mem [`WBB_SLV_WORDS];

	logic accept;

	// Busy for the one cycle the ack is out
	assign o_stall = o_ack;
	assign accept  = i_cyc && i_stb && !o_stall;

	// RAM never signals a bus error
	assign o_err = 1'b0;

	//////////////////////////////////////////////////////////////////////
	// Memory array

	always_ff @(posedge i_clk)
	begin
		if (accept && i_we)
		begin
			// Only the selected byte lanes change
			for (int b = 0; b < `WBB_SEL_W; b++)
			begin
				if (i_sel[b])
					mem[i_addr][8*b +: 8] <= i_data[8*b +: 8];
			end
		end
	end

	// Old word is returned on a read
	always_ff @(posedge i_clk)
	begin
		if (accept && !i_we)
			o_rdata <= mem[i_addr];
	end

	//////////////////////////////////////////////////////////////////////
	// Ack one cycle after acceptance

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || !i_cyc)
			o_ack <= 1'b0;
		else
			o_ack <= accept;
	end

	// Upstream holds off new strobes while the ack is out
	a_no_accept_pending: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		o_ack |-> !(i_cyc && i_stb));

endmodule

// ==== wbp_decoder.sv ====
//////////////////////////////////////////////////////////////////////
// Pipelined Wishbone address decoder
// Routes each strobe to one slave and records the target
// Answers addresses without a slave with a one-cycle error
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module wbp_decoder (
	input  logic                    i_clk,
	input  logic                    i_rst_n,
	// Upstream pipelined port
	input  logic                    i_cyc,
	input  logic                    i_stb,
	input  logic                    i_we,
	input  wbb_bus_pkg::addr_t      i_addr,
	input  wbb_bus_pkg::data_t      i_data,
	input  wbb_bus_pkg::sel_t       i_sel,
	output logic                    o_stall,
	// Shared slave request lines and one strobe per slave
	output logic                    o_scyc,
	output logic [`WBB_N_SLAVES-1:0] o_sstb,
	output logic                    o_swe,
	output wbb_bus_pkg::slv_addr_t  o_saddr,
	output wbb_bus_pkg::data_t      o_sdata,
	output wbb_bus_pkg::sel_t       o_ssel,
	input  logic [`WBB_N_SLAVES-1:0] i_sstall,
	// Any response seen by the mux
	input  logic                    i_resp,
	output wbb_map_pkg::slv_idx_t   o_idx,
	output logic                    o_err
);

	localparam wbb_map_pkg::slv_idx_t LAST_IDX =
		wbb_map_pkg::slv_idx_t'(`WBB_N_SLAVES - 1);

	wbb_map_pkg::dec_state_e state;
	wbb_map_pkg::slv_idx_t   req_idx;
	logic                    mapped;
	logic                    idle;
	logic                    sel_stall;
	logic                    accept;

	//////////////////////////////////////////////////////////////////////
	// Address split and routing

	assign req_idx = i_addr[`WBB_AW-1:`WBB_SLV_AW];
	assign mapped  = (req_idx <= LAST_IDX);
	assign idle    = (state == wbb_map_pkg::DEC_IDLE);

	// Stall of the addressed slave only
	always_comb
	begin
		sel_stall = 1'b0;
		o_sstb    = '0;
		for (int k = 0; k < `WBB_N_SLAVES; k++)
		begin
			if (req_idx == wbb_map_pkg::slv_idx_t'(k))
			begin
				sel_stall = i_sstall[k];
				// No new strobe while a response is still owed
				o_sstb[k] = i_cyc && i_stb && idle;
			end
		end
	end

	assign o_stall = !idle || (mapped && sel_stall);
	assign accept  = i_cyc && i_stb && !o_stall;

	assign o_scyc  = i_cyc;
	assign o_swe   = i_we;
	assign o_saddr = i_addr[`WBB_SLV_AW-1:0];
	assign o_sdata = i_data;
	assign o_ssel  = i_sel;

	//////////////////////////////////////////////////////////////////////
	// Outstanding target FSM

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n)
		begin
			state <= wbb_map_pkg::DEC_IDLE;
			o_idx <= '0;
			o_err <= 1'b0;
		end
		else
		begin
			// Error reply lasts a single cycle
			o_err <= 1'b0;
			case (state)
				wbb_map_pkg::DEC_IDLE:
				begin
					if (accept)
					begin
						o_idx <= req_idx;
						if (mapped)
							state <= wbb_map_pkg::DEC_WAIT_SLV;
						else
						begin
							state <= wbb_map_pkg::DEC_ERR;
							o_err <= 1'b1;
						end
					end
				end
				// Abandoned cycles also release the target
				wbb_map_pkg::DEC_WAIT_SLV,
				wbb_map_pkg::DEC_ERR:
				begin
					if (i_resp || !i_cyc)
						state <= wbb_map_pkg::DEC_IDLE;
				end
				default:
					state <= wbb_map_pkg::DEC_IDLE;
			endcase
		end
	end

	// Slaves and the error path answer only while a response is owed
	a_resp_owed: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_resp |-> !idle);

endmodule

// ==== wbc2pipeline.sv ====
//////////////////////////////////////////////////////////////////////
// Wishbone classic to pipelined bridge
// Issues one pipelined strobe per classic request
// Registers ack, error and read data back to the classic master
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

module wbc2pipeline (
	input  logic                i_clk,
	input  logic                i_rst_n,
	// Classic master side
	input  logic                i_mcyc,
	input  logic                i_mstb,
	input  logic                i_mwe,
	input  wbb_bus_pkg::addr_t  i_maddr,
	input  wbb_bus_pkg::data_t  i_mdata,
	input  wbb_bus_pkg::sel_t   i_msel,
	output logic                o_mack,
	output logic                o_merr,
	output wbb_bus_pkg::data_t  o_mdata,
	// Pipelined slave side
	output logic                o_scyc,
	output logic                o_sstb,
	output logic                o_swe,
	output wbb_bus_pkg::addr_t  o_saddr,
	output wbb_bus_pkg::data_t  o_sdata,
	output wbb_bus_pkg::sel_t   o_ssel,
	input  logic                i_sstall,
	input  logic                i_sack,
	input  logic                i_serr,
	input  wbb_bus_pkg::data_t  i_sdata
);

	// Current classic strobe already taken downstream
	logic sent;

	// Request ends when the strobe drops or a response went back
	logic req_done;
	assign req_done = !i_mstb || o_mack || o_merr;

	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || req_done)
			sent <= 1'b0;
		else if (!i_sstall)
			sent <= 1'b1;
	end

	// Request fields pass straight through
	// Strobe is masked once accepted and both drop in the error cycle
	assign o_scyc  = i_mcyc && !o_merr;
	assign o_sstb  = i_mstb && !sent && !o_merr;
	assign o_swe   = i_mwe;
	assign o_saddr = i_maddr;
	assign o_sdata = i_mdata;
	assign o_ssel  = i_msel;

	// One-cycle response pulses toward the classic master
	always_ff @(posedge i_clk)
	begin
		if (!i_rst_n || req_done)
		begin
			o_mack <= 1'b0;
			o_merr <= 1'b0;
		end
		else
		begin
			o_mack <= i_sack;
			o_merr <= i_serr;
		end
	end

	// Read data is captured with the ack
	always_ff @(posedge i_clk)
	begin
		if (i_sack)
			o_mdata <= i_sdata;
	end

	// Slave ack and decoder error never reach the master together
	a_ack_err_excl: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		!(o_mack && o_merr));

endmodule

// ==== wbb_map_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Address map types
// Slave index vector and decoder state encoding
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

package wbb_map_pkg;

	// Slave index from the top address bits
	typedef logic [`WBB_IDX_W-1:0] slv_idx_t;

	// Decoder FSM states
	typedef enum logic [1:0] {
		DEC_IDLE     = 2'd0,
		DEC_WAIT_SLV = 2'd1,
		DEC_ERR      = 2'd2
	} dec_state_e;

endpackage

// ==== wbb_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// Bus payload types
// Address, data, byte select and slave-local address vectors
//////////////////////////////////////////////////////////////////////
`include "wbb_cfg.svh"

package wbb_bus_pkg;

	// Full word address as seen by the master
	typedef logic [`WBB_AW-1:0] addr_t;

	// One bus data word
	typedef logic [`WBB_DW-1:0] data_t;

	// One bit per byte lane of data_t
	typedef logic [`WBB_SEL_W-1:0] sel_t;

	// Word offset inside one slave window
	typedef logic [`WBB_SLV_AW-1:0] slv_addr_t;

endpackage

// ==== wbb_cfg.svh ====
//////////////////////////////////////////////////////////////////////
// Bus geometry for the Wishbone bridge subsystem
// Address and data widths, slave count and slave window size
//////////////////////////////////////////////////////////////////////
`ifndef WBB_CFG_SVH
`define WBB_CFG_SVH

// Word address width on the pipelined bus
`define WBB_AW 10

// Data width of every bus in the subsystem
`define WBB_DW 32

// Byte lanes per data word
`define WBB_SEL_W (`WBB_DW / 8)

// Address bits inside one slave window
`define WBB_SLV_AW 8
`define WBB_SLV_WORDS (1 << `WBB_SLV_AW)

// RAM slaves present and the index width of the address map
`define WBB_N_SLAVES 3
`define WBB_IDX_W (`WBB_AW - `WBB_SLV_AW)

`endif
